// File: design/ex_pkg.sv
package ex_pkg;

	// datapath widths fixed by RV32I
	localparam int DATA_W = 32;
	localparam int REG_W  = 5;

	// EX control word layout
	localparam int EX_CTRL_W   = 8;
	localparam int BRU_OP_HI   = 7;
	localparam int BRU_OP_LO   = 5;
	localparam int ALU_OP_HI   = 4;
	localparam int ALU_OP_LO   = 1;
	localparam int ALU_SRC_BIT = 0;

	// MEM control word layout
	localparam int MEM_CTRL_W    = 2;
	localparam int MEM_READ_BIT  = 0;
	localparam int MEM_WRITE_BIT = 1;

	// WB control word layout
	localparam int WB_CTRL_W      = 2;
	localparam int REG_WRITE_BIT  = 0;
	localparam int MEM_TO_REG_BIT = 1;

	// forwarding source select, code 3 unused
	localparam int FW_W = 2;
	localparam logic [FW_W-1:0] FW_REG    = 2'd0;
	localparam logic [FW_W-1:0] FW_MEM_WB = 2'd1;
	localparam logic [FW_W-1:0] FW_EX_MEM = 2'd2;

	// ALU operations
	localparam int ALU_OP_W = 4;
	localparam logic [ALU_OP_W-1:0] ALU_ADD  = 4'd0;
	localparam logic [ALU_OP_W-1:0] ALU_SUB  = 4'd1;
	localparam logic [ALU_OP_W-1:0] ALU_AND  = 4'd2;
	localparam logic [ALU_OP_W-1:0] ALU_OR   = 4'd3;
	localparam logic [ALU_OP_W-1:0] ALU_XOR  = 4'd4;
	localparam logic [ALU_OP_W-1:0] ALU_SLL  = 4'd5;
	localparam logic [ALU_OP_W-1:0] ALU_SRL  = 4'd6;
	localparam logic [ALU_OP_W-1:0] ALU_SRA  = 4'd7;
	localparam logic [ALU_OP_W-1:0] ALU_SLT  = 4'd8;
	localparam logic [ALU_OP_W-1:0] ALU_SLTU = 4'd9;

	// branch conditions
	localparam int BRU_OP_W = 3;
	localparam logic [BRU_OP_W-1:0] BRU_NONE = 3'd0;
	localparam logic [BRU_OP_W-1:0] BRU_EQ   = 3'd1;
	localparam logic [BRU_OP_W-1:0] BRU_NE   = 3'd2;
	localparam logic [BRU_OP_W-1:0] BRU_LT   = 3'd3;
	localparam logic [BRU_OP_W-1:0] BRU_GE   = 3'd4;
	localparam logic [BRU_OP_W-1:0] BRU_LTU  = 3'd5;
	localparam logic [BRU_OP_W-1:0] BRU_GEU  = 3'd6;

endpackage

// File: design/forward_unit.sv
module forward_unit (
	input  logic [ex_pkg::REG_W-1:0] rs1,
	input  logic [ex_pkg::REG_W-1:0] rs2,
	input  logic [ex_pkg::REG_W-1:0] ex_mem_rd,
	input  logic [ex_pkg::REG_W-1:0] mem_wb_rd,
	input  logic                     ex_mem_reg_write,
	input  logic                     mem_wb_reg_write,
	output logic [ex_pkg::FW_W-1:0]  fw_a,
	output logic [ex_pkg::FW_W-1:0]  fw_b
);

	import ex_pkg::*;

	// newest producer wins and x0 is never forwarded
	function automatic logic [FW_W-1:0] fw_select(
		input logic [REG_W-1:0] rs,
		input logic [REG_W-1:0] em_rd,
		input logic             em_we,
		input logic [REG_W-1:0] mw_rd,
		input logic             mw_we
	);
		if (em_we && (em_rd != '0) && (em_rd == rs))
			return FW_EX_MEM;
		else if (mw_we && (mw_rd != '0) && (mw_rd == rs))
			return FW_MEM_WB;
		else
			return FW_REG;
	endfunction

	assign fw_a = fw_select(rs1, ex_mem_rd, ex_mem_reg_write, mem_wb_rd, mem_wb_reg_write);
	assign fw_b = fw_select(rs2, ex_mem_rd, ex_mem_reg_write, mem_wb_rd, mem_wb_reg_write);

endmodule

// File: design/alu.sv
module alu (
	input  logic [ex_pkg::DATA_W-1:0]   src1,
	input  logic [ex_pkg::DATA_W-1:0]   src2,
	input  logic [ex_pkg::ALU_OP_W-1:0] alu_op,
	output logic [ex_pkg::DATA_W-1:0]   result
);

	import ex_pkg::*;

	logic [4:0] shamt;

	// only the low five bits count for shifts
	assign shamt = src2[4:0];

	always_comb begin
		unique case (alu_op)
			ALU_ADD:  result = src1 + src2;
			ALU_SUB:  result = src1 - src2;
			ALU_AND:  result = src1 & src2;
			ALU_OR:   result = src1 | src2;
			ALU_XOR:  result = src1 ^ src2;
			ALU_SLL:  result = src1 << shamt;
			ALU_SRL:  result = src1 >> shamt;
			ALU_SRA:  result = $signed(src1) >>> shamt;
			ALU_SLT:  result = {{(DATA_W-1){1'b0}}, $signed(src1) < $signed(src2)};
			ALU_SLTU: result = {{(DATA_W-1){1'b0}}, src1 < src2};
			default:  result = '0;
		endcase
	end

	// decode only hands out the ten defined codes
	always_comb begin
		if (!$isunknown(alu_op)) begin
			assert (alu_op <= ALU_SLTU)
				else $error("alu: undefined op %0d", alu_op);
		end
	end

endmodule

// File: design/branch_unit.sv
module branch_unit (
	input  logic [ex_pkg::DATA_W-1:0]   src1,
	input  logic [ex_pkg::DATA_W-1:0]   src2,
	input  logic [ex_pkg::BRU_OP_W-1:0] bru_op,
	output logic                        taken
);

	import ex_pkg::*;

	// compares forwarded register values only
	always_comb begin
		unique case (bru_op)
			BRU_NONE: taken = 1'b0;
			BRU_EQ:   taken = (src1 == src2);
			BRU_NE:   taken = (src1 != src2);
			BRU_LT:   taken = ($signed(src1) < $signed(src2));
			BRU_GE:   taken = ($signed(src1) >= $signed(src2));
			BRU_LTU:  taken = (src1 < src2);
			BRU_GEU:  taken = (src1 >= src2);
			default:  taken = 1'b0;
		endcase
	end

endmodule

// File: design/execute_stage.sv
module execute_stage (
	input  logic [ex_pkg::EX_CTRL_W-1:0] ex_ctrl,
	input  logic [ex_pkg::DATA_W-1:0]    reg_data1,
	input  logic [ex_pkg::DATA_W-1:0]    reg_data2,
	input  logic [ex_pkg::DATA_W-1:0]    imm,
	input  logic [ex_pkg::REG_W-1:0]     rs1,
	input  logic [ex_pkg::REG_W-1:0]     rs2,
	input  logic [ex_pkg::DATA_W-1:0]    ex_mem_data,
	input  logic [ex_pkg::DATA_W-1:0]    mem_wb_data,
	input  logic [ex_pkg::REG_W-1:0]     ex_mem_rd,
	input  logic [ex_pkg::REG_W-1:0]     mem_wb_rd,
	input  logic                         ex_mem_reg_write,
	input  logic                         mem_wb_reg_write,
	output logic [ex_pkg::DATA_W-1:0]    alu_result,
	output logic [ex_pkg::DATA_W-1:0]    store_data,
	output logic                         branch_taken,
	output logic                         is_branch
);

	import ex_pkg::*;

	logic [ALU_OP_W-1:0] alu_op;
	logic [BRU_OP_W-1:0] bru_op;
	logic                alu_src;
	logic [FW_W-1:0]     fw_a;
	logic [FW_W-1:0]     fw_b;
	logic [DATA_W-1:0]   src1;
	logic [DATA_W-1:0]   src2_fw;
	logic [DATA_W-1:0]   src2;

	function automatic logic [DATA_W-1:0] fw_mux(
		input logic [FW_W-1:0]   sel,
		input logic [DATA_W-1:0] reg_val,
		input logic [DATA_W-1:0] mem_wb_val,
		input logic [DATA_W-1:0] ex_mem_val
	);
		case (sel)
			FW_EX_MEM: return ex_mem_val;
			FW_MEM_WB: return mem_wb_val;
			default:   return reg_val;
		endcase
	endfunction

	// control field decode
	assign bru_op  = ex_ctrl[BRU_OP_HI:BRU_OP_LO];
	assign alu_op  = ex_ctrl[ALU_OP_HI:ALU_OP_LO];
	assign alu_src = ex_ctrl[ALU_SRC_BIT];

	assign src1    = fw_mux(fw_a, reg_data1, mem_wb_data, ex_mem_data);
	assign src2_fw = fw_mux(fw_b, reg_data2, mem_wb_data, ex_mem_data);

	// immediate replaces B for the ALU but never for stores or branches
	assign src2       = alu_src ? imm : src2_fw;
	assign store_data = src2_fw;
	assign is_branch  = (bru_op != BRU_NONE);

	forward_unit forward_i (
		.rs1,
		.rs2,
		.ex_mem_rd,
		.mem_wb_rd,
		.ex_mem_reg_write,
		.mem_wb_reg_write,
		.fw_a,
		.fw_b
	);

	alu alu_i (
		.src1,
		.src2,
		.alu_op,
		.result (alu_result)
	);

	branch_unit branch_i (
		.src1,
		.src2   (src2_fw),
		.bru_op,
		.taken  (branch_taken)
	);

endmodule

// File: design/retire_latches.sv
module retire_latches (
	input  logic                          clk,
	input  logic                          reset,
	input  logic                          ex_valid,
	input  logic [ex_pkg::DATA_W-1:0]     alu_result,
	input  logic [ex_pkg::DATA_W-1:0]     store_data,
	input  logic                          branch_taken,
	input  logic                          is_branch,
	input  logic [ex_pkg::MEM_CTRL_W-1:0] mem_ctrl,
	input  logic [ex_pkg::WB_CTRL_W-1:0]  wb_ctrl,
	input  logic [ex_pkg::REG_W-1:0]      ex_rd,
	input  logic [ex_pkg::DATA_W-1:0]     load_data,
	output logic [ex_pkg::DATA_W-1:0]     mem_addr,
	output logic [ex_pkg::DATA_W-1:0]     mem_store_data,
	output logic                          mem_read,
	output logic                          mem_write,
	output logic                          branch_valid,
	output logic                          branch_taken_out,
	output logic [ex_pkg::DATA_W-1:0]     ex_mem_data,
	output logic [ex_pkg::REG_W-1:0]      ex_mem_rd,
	output logic                          ex_mem_reg_write,
	output logic [ex_pkg::DATA_W-1:0]     mem_wb_data,
	output logic [ex_pkg::REG_W-1:0]      mem_wb_rd,
	output logic                          mem_wb_reg_write,
	output logic                          wb_valid,
	output logic [ex_pkg::REG_W-1:0]      wb_rd,
	output logic [ex_pkg::DATA_W-1:0]     wb_data
);

	import ex_pkg::*;

	logic                  ex_mem_valid;
	logic                  mem_wb_valid;
	logic [DATA_W-1:0]     ex_mem_store;
	logic                  ex_mem_taken;
	logic                  ex_mem_is_branch;
	logic [MEM_CTRL_W-1:0] ex_mem_mem_ctrl;
	logic [WB_CTRL_W-1:0]  ex_mem_wb_ctrl;
	logic                  mem_wb_write_en;
	logic [DATA_W-1:0]     mem_result;

	always_ff @(posedge clk) begin
		if (reset) begin
			ex_mem_valid <= 1'b0;
			mem_wb_valid <= 1'b0;
		end else begin
			ex_mem_valid <= ex_valid;
			mem_wb_valid <= ex_mem_valid;
		end
	end

	// EX/MEM payload
	always_ff @(posedge clk) begin
		ex_mem_data      <= alu_result;
		ex_mem_store     <= store_data;
		ex_mem_taken     <= branch_taken;
		ex_mem_is_branch <= is_branch;
		ex_mem_mem_ctrl  <= mem_ctrl;
		ex_mem_wb_ctrl   <= wb_ctrl;
		ex_mem_rd        <= ex_rd;
	end

	// memory port, load data arrives in the same cycle
	assign mem_addr         = ex_mem_data;
	assign mem_store_data   = ex_mem_store;
	assign mem_read         = ex_mem_valid & ex_mem_mem_ctrl[MEM_READ_BIT];
	assign mem_write        = ex_mem_valid & ex_mem_mem_ctrl[MEM_WRITE_BIT];
	assign branch_valid     = ex_mem_valid & ex_mem_is_branch;
	assign branch_taken_out = branch_valid & ex_mem_taken;
	assign ex_mem_reg_write = ex_mem_valid & ex_mem_wb_ctrl[REG_WRITE_BIT];

	assign mem_result = ex_mem_wb_ctrl[MEM_TO_REG_BIT] ? load_data : ex_mem_data;

	// MEM/WB payload
	always_ff @(posedge clk) begin
		mem_wb_data     <= mem_result;
		mem_wb_rd       <= ex_mem_rd;
		mem_wb_write_en <= ex_mem_wb_ctrl[REG_WRITE_BIT];
	end

	assign mem_wb_reg_write = mem_wb_valid & mem_wb_write_en;

	// writes aimed at x0 are dropped at the port
	assign wb_valid = mem_wb_reg_write & (mem_wb_rd != '0);
	assign wb_rd    = mem_wb_rd;
	assign wb_data  = mem_wb_data;

	assert property (@(posedge clk) disable iff (reset) !(mem_read && mem_write))
		else $error("retire_latches: load and store in the same slot");

endmodule

// File: design/ex_pipeline.sv
module ex_pipeline (
	input  logic                          clk,
	input  logic                          reset,
	input  logic                          issue_valid,
	input  logic [ex_pkg::EX_CTRL_W-1:0]  ex_ctrl,
	input  logic [ex_pkg::MEM_CTRL_W-1:0] mem_ctrl,
	input  logic [ex_pkg::WB_CTRL_W-1:0]  wb_ctrl,
	input  logic [ex_pkg::DATA_W-1:0]     reg_data1,
	input  logic [ex_pkg::DATA_W-1:0]     reg_data2,
	input  logic [ex_pkg::DATA_W-1:0]     imm,
	input  logic [ex_pkg::REG_W-1:0]      rs1,
	input  logic [ex_pkg::REG_W-1:0]      rs2,
	input  logic [ex_pkg::REG_W-1:0]      rd,
	input  logic [ex_pkg::DATA_W-1:0]     load_data,
	output logic [ex_pkg::DATA_W-1:0]     mem_addr,
	output logic [ex_pkg::DATA_W-1:0]     store_data,
	output logic                          mem_read,
	output logic                          mem_write,
	output logic                          load_pending,
	output logic                          branch_valid,
	output logic                          branch_taken,
	output logic                          wb_valid,
	output logic [ex_pkg::REG_W-1:0]      wb_rd,
	output logic [ex_pkg::DATA_W-1:0]     wb_data
);

	import ex_pkg::*;

	// ID/EX register
	logic                  id_ex_valid;
	logic [EX_CTRL_W-1:0]  id_ex_ex_ctrl;
	logic [MEM_CTRL_W-1:0] id_ex_mem_ctrl;
	logic [WB_CTRL_W-1:0]  id_ex_wb_ctrl;
	logic [DATA_W-1:0]     id_ex_data1;
	logic [DATA_W-1:0]     id_ex_data2;
	logic [DATA_W-1:0]     id_ex_imm;
	logic [REG_W-1:0]      id_ex_rs1;
	logic [REG_W-1:0]      id_ex_rs2;
	logic [REG_W-1:0]      id_ex_rd;

	// execute results and forwarding paths
	logic [DATA_W-1:0] alu_result;
	logic [DATA_W-1:0] ex_store_data;
	logic              ex_branch_taken;
	logic              is_branch;
	logic [DATA_W-1:0] ex_mem_data;
	logic [REG_W-1:0]  ex_mem_rd;
	logic              ex_mem_reg_write;
	logic [DATA_W-1:0] mem_wb_data;
	logic [REG_W-1:0]  mem_wb_rd;
	logic              mem_wb_reg_write;

	always_ff @(posedge clk) begin
		if (reset)
			id_ex_valid <= 1'b0;
		else
			id_ex_valid <= issue_valid;
	end

	// payload only moves on a strobe
	always_ff @(posedge clk) begin
		if (issue_valid) begin
			id_ex_ex_ctrl  <= ex_ctrl;
			id_ex_mem_ctrl <= mem_ctrl;
			id_ex_wb_ctrl  <= wb_ctrl;
			id_ex_data1    <= reg_data1;
			id_ex_data2    <= reg_data2;
			id_ex_imm      <= imm;
			id_ex_rs1      <= rs1;
			id_ex_rs2      <= rs2;
			id_ex_rd       <= rd;
		end
	end

	// tells hazard logic a load sits in EX
	assign load_pending = id_ex_valid & id_ex_mem_ctrl[MEM_READ_BIT];

	execute_stage execute_i (
		.ex_ctrl          (id_ex_ex_ctrl),
		.reg_data1        (id_ex_data1),
		.reg_data2        (id_ex_data2),
		.imm              (id_ex_imm),
		.rs1              (id_ex_rs1),
		.rs2              (id_ex_rs2),
		.ex_mem_data,
		.mem_wb_data,
		.ex_mem_rd,
		.mem_wb_rd,
		.ex_mem_reg_write,
		.mem_wb_reg_write,
		.alu_result,
		.store_data       (ex_store_data),
		.branch_taken     (ex_branch_taken),
		.is_branch
	);

	retire_latches retire_i (
		.clk,
		.reset,
		.ex_valid         (id_ex_valid),
		.alu_result,
		.store_data       (ex_store_data),
		.branch_taken     (ex_branch_taken),
		.is_branch,
		.mem_ctrl         (id_ex_mem_ctrl),
		.wb_ctrl          (id_ex_wb_ctrl),
		.ex_rd            (id_ex_rd),
		.load_data,
		.mem_addr,
		.mem_store_data   (store_data),
		.mem_read,
		.mem_write,
		.branch_valid,
		.branch_taken_out (branch_taken),
		.ex_mem_data,
		.ex_mem_rd,
		.ex_mem_reg_write,
		.mem_wb_data,
		.mem_wb_rd,
		.mem_wb_reg_write,
		.wb_valid,
		.wb_rd,
		.wb_data
	);

endmodule

// File: testbench/ex_pipeline_tb.sv
module ex_pipeline_tb;

	import ex_pkg::*;

	localparam int NUM_SLOTS  = 35;
	localparam int FIELDS     = 8;
	localparam int MAX_CYCLES = NUM_SLOTS + 40;
	localparam int EXP_DEPTH  = MAX_CYCLES + 4;

	logic                  clk;
	logic                  reset;
	logic                  issue_valid;
	logic [EX_CTRL_W-1:0]  ex_ctrl;
	logic [MEM_CTRL_W-1:0] mem_ctrl;
	logic [WB_CTRL_W-1:0]  wb_ctrl;
	logic [DATA_W-1:0]     reg_data1;
	logic [DATA_W-1:0]     reg_data2;
	logic [DATA_W-1:0]     imm;
	logic [REG_W-1:0]      rs1;
	logic [REG_W-1:0]      rs2;
	logic [REG_W-1:0]      rd;
	logic [DATA_W-1:0]     load_data;
	logic [DATA_W-1:0]     mem_addr;
	logic [DATA_W-1:0]     store_data;
	logic                  mem_read;
	logic                  mem_write;
	logic                  load_pending;
	logic                  branch_valid;
	logic                  branch_taken;
	logic                  wb_valid;
	logic [REG_W-1:0]      wb_rd;
	logic [DATA_W-1:0]     wb_data;

	logic [31:0]       slot_words [0:NUM_SLOTS*FIELDS-1];
	logic [DATA_W-1:0] arch_regs [0:31];
	logic [DATA_W-1:0] model_regs [0:31];
	logic [DATA_W-1:0] data_mem [0:15];
	logic [DATA_W-1:0] model_mem [0:15];
	logic [15:0]       lfsr;
	int                cycle;
	int                value_errors;
	int                setup_errors;

	// expected outputs, indexed by cycle after reset
	logic              exp_pending [0:EXP_DEPTH-1];
	logic [1:0]        exp_mem_rw [0:EXP_DEPTH-1];
	logic [DATA_W-1:0] exp_addr [0:EXP_DEPTH-1];
	logic [DATA_W-1:0] exp_store [0:EXP_DEPTH-1];
	logic [1:0]        exp_branch [0:EXP_DEPTH-1];
	logic              exp_wb_valid [0:EXP_DEPTH-1];
	logic [REG_W-1:0]  exp_wb_rd [0:EXP_DEPTH-1];
	logic [DATA_W-1:0] exp_wb_data [0:EXP_DEPTH-1];

	ex_pipeline dut_i (.*);

	always #20 clk = ~clk;

	// data memory answers loads in the same cycle
	assign load_data = mem_read ? data_mem[mem_addr[5:2]] : '0;

	always @(posedge clk) begin
		if (reset)
			data_mem <= model_mem;
		else if (mem_write)
			data_mem[mem_addr[5:2]] <= store_data;
	end

	function automatic logic [15:0] lfsr_next(input logic [15:0] state);
		return state[0] ? ((state >> 1) ^ 16'hb400) : (state >> 1);
	endfunction

	task automatic draw_word(output logic [DATA_W-1:0] word);
		word = '0;
		for (int i = 0; i < DATA_W; i++) begin
			word = {word[DATA_W-2:0], lfsr[0]};
			lfsr = lfsr_next(lfsr);
		end
	endtask

	function automatic logic less_signed(input logic [DATA_W-1:0] a, input logic [DATA_W-1:0] b);
		// differing signs decide alone
		return (a[DATA_W-1] != b[DATA_W-1]) ? a[DATA_W-1] : (a < b);
	endfunction

	function automatic logic [DATA_W-1:0] alu_ref(input logic [ALU_OP_W-1:0] op,
			input logic [DATA_W-1:0] a, input logic [DATA_W-1:0] b);
		case (op)
			ALU_ADD:  return a + b;
			ALU_SUB:  return a + ~b + 1;
			ALU_AND:  return a & b;
			ALU_OR:   return a | b;
			ALU_XOR:  return a ^ b;
			ALU_SLL:  return a << b[4:0];
			ALU_SRL:  return a >> b[4:0];
			ALU_SRA:  return (a >> b[4:0]) | (a[DATA_W-1] ? ~({DATA_W{1'b1}} >> b[4:0]) : '0);
			ALU_SLT:  return {{(DATA_W-1){1'b0}}, less_signed(a, b)};
			ALU_SLTU: return {{(DATA_W-1){1'b0}}, a < b};
			default:  return '0;
		endcase
	endfunction

	function automatic logic branch_ref(input logic [BRU_OP_W-1:0] op,
			input logic [DATA_W-1:0] a, input logic [DATA_W-1:0] b);
		case (op)
			BRU_EQ:  return a == b;
			BRU_NE:  return a != b;
			BRU_LT:  return less_signed(a, b);
			BRU_GE:  return !less_signed(a, b);
			BRU_LTU: return a < b;
			BRU_GEU: return !(a < b);
			default: return 1'b0;
		endcase
	endfunction

	// decode reads a write-first register file, so a result retiring now reads through
	function automatic logic [DATA_W-1:0] reg_read(input logic [REG_W-1:0] r, input int s);
		if (r == '0)
			return '0;
		else if (exp_wb_valid[s] && exp_wb_rd[s] == r)
			return exp_wb_data[s];
		else
			return arch_regs[r];
	endfunction

	task automatic issue_slot(input int idx, input int s);
		int                    base;
		logic                  v;
		logic [EX_CTRL_W-1:0]  exc;
		logic [MEM_CTRL_W-1:0] mc;
		logic [WB_CTRL_W-1:0]  wc;
		logic [REG_W-1:0]      r1;
		logic [REG_W-1:0]      r2;
		logic [REG_W-1:0]      rdi;
		logic [DATA_W-1:0]     immv;
		logic [DATA_W-1:0]     a;
		logic [DATA_W-1:0]     b;
		logic [DATA_W-1:0]     res;
		base = idx * FIELDS;
		v    = slot_words[base][0];
		exc  = slot_words[base + 1][EX_CTRL_W-1:0];
		mc   = slot_words[base + 2][MEM_CTRL_W-1:0];
		wc   = slot_words[base + 3][WB_CTRL_W-1:0];
		r1   = slot_words[base + 4][REG_W-1:0];
		r2   = slot_words[base + 5][REG_W-1:0];
		rdi  = slot_words[base + 6][REG_W-1:0];
		immv = slot_words[base + 7];
		issue_valid <= v;
		ex_ctrl     <= exc;
		mem_ctrl    <= mc;
		wb_ctrl     <= wc;
		reg_data1   <= reg_read(r1, s);
		reg_data2   <= reg_read(r2, s);
		imm         <= immv;
		rs1         <= r1;
		rs2         <= r2;
		rd          <= rdi;
		if (v) begin
			// in-order model on the correct register copy
			a   = model_regs[r1];
			b   = model_regs[r2];
			res = alu_ref(exc[ALU_OP_HI:ALU_OP_LO], a, exc[ALU_SRC_BIT] ? immv : b);
			exp_pending[s + 1] = mc[MEM_READ_BIT];
			exp_mem_rw[s + 2]  = mc;
			exp_addr[s + 2]    = res;
			exp_store[s + 2]   = b;
			exp_branch[s + 2]  = {exc[BRU_OP_HI:BRU_OP_LO] != BRU_NONE,
				branch_ref(exc[BRU_OP_HI:BRU_OP_LO], a, b)};
			if (mc[MEM_WRITE_BIT])
				model_mem[res[5:2]] = b;
			if (mc[MEM_READ_BIT])
				res = model_mem[res[5:2]];
			if (wc[REG_WRITE_BIT] && rdi != '0) begin
				model_regs[rdi]     = res;
				exp_wb_valid[s + 3] = 1'b1;
				exp_wb_rd[s + 3]    = rdi;
				exp_wb_data[s + 3]  = res;
			end
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic want);
		assert (got === want)
		else begin
			value_errors++;
			$display("error at %0t: %s is %b, expected %b", $time, name, got, want);
		end
	endtask

	task automatic check_word(input string name, input logic [DATA_W-1:0] got,
			input logic [DATA_W-1:0] want);
		assert (got === want)
		else begin
			value_errors++;
			$display("error at %0t: %s is %h, expected %h", $time, name, got, want);
		end
	endtask

	// outputs settle by the falling edge
	always @(negedge clk) begin
		if (reset) begin
			arch_regs = model_regs;
		end else begin
			check_bit("load_pending", load_pending, exp_pending[cycle]);
			check_bit("mem_read", mem_read, exp_mem_rw[cycle][MEM_READ_BIT]);
			check_bit("mem_write", mem_write, exp_mem_rw[cycle][MEM_WRITE_BIT]);
			if (exp_mem_rw[cycle] != '0) begin
				check_word("mem_addr", mem_addr, exp_addr[cycle]);
				check_word("store_data", store_data, exp_store[cycle]);
			end
			check_bit("branch_valid", branch_valid, exp_branch[cycle][1]);
			check_bit("branch_taken", branch_taken, exp_branch[cycle][0]);
			check_bit("wb_valid", wb_valid, exp_wb_valid[cycle]);
			if (exp_wb_valid[cycle]) begin
				check_word("wb_rd", DATA_W'(wb_rd), DATA_W'(exp_wb_rd[cycle]));
				check_word("wb_data", wb_data, exp_wb_data[cycle]);
			end
			if (wb_valid)
				arch_regs[wb_rd] = wb_data;
		end
	end

	always @(posedge clk) begin
		if (reset) begin
			cycle <= 0;
		end else if (cycle >= MAX_CYCLES) begin
			$display("timeout: run still going after %0d cycles", cycle);
			$display("TEST FAILED");
			$finish;
		end else begin
			cycle <= cycle + 1;
		end
	end

	initial begin
		clk         = 1'b0;
		reset       = 1'b1;
		issue_valid = 1'b0;
		ex_ctrl     = '0;
		mem_ctrl    = '0;
		wb_ctrl     = '0;
		reg_data1   = '0;
		reg_data2   = '0;
		imm         = '0;
		rs1         = '0;
		rs2         = '0;
		rd          = '0;
		for (int i = 0; i < EXP_DEPTH; i++) begin
			exp_pending[i]  = 1'b0;
			exp_mem_rw[i]   = '0;
			exp_addr[i]     = '0;
			exp_store[i]    = '0;
			exp_branch[i]   = '0;
			exp_wb_valid[i] = 1'b0;
			exp_wb_rd[i]    = '0;
			exp_wb_data[i]  = '0;
		end
		lfsr = 16'd16;
		model_regs[0] = '0;
		for (int i = 1; i < 32; i++)
			draw_word(model_regs[i]);
		for (int i = 0; i < 16; i++)
			draw_word(model_mem[i]);
		for (int i = 0; i < NUM_SLOTS * FIELDS; i++)
			slot_words[i] = '1;
		$readmemh("testbench/ex_testdata.mem", slot_words);
		assert (slot_words[(NUM_SLOTS - 1) * FIELDS] <= 32'd1)
		else begin
			setup_errors++;
			$display("stimulus file holds fewer slots than the testbench expects");
		end
		repeat (16) @(posedge clk);
		reset <= 1'b0;
		for (int i = 0; i < NUM_SLOTS; i++) begin
			@(posedge clk);
			issue_slot(i, cycle + 1);
		end
		@(posedge clk);
		issue_valid <= 1'b0;
		// last write-back lands three cycles after its strobe
		repeat (4) @(posedge clk);
		$display("summary: %0d value errors, %0d setup errors over %0d slots",
			value_errors, setup_errors, NUM_SLOTS);
		if (value_errors == 0 && setup_errors == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

// File: testbench/ex_testdata.mem
// valid ex_ctrl mem_ctrl wb_ctrl rs1 rs2 rd imm, one issue slot per line
// ex_ctrl is {bru_op, alu_op, alu_src}; mem_ctrl is {write, read}; wb_ctrl is {mem_to_reg, reg_write}
1 00 0 1 01 02 03 00000000
1 03 0 1 03 00 04 00000123
1 04 0 1 03 04 05 00000000
1 05 0 1 05 00 06 0000f0f0
1 06 0 1 06 07 07 00000000
1 07 0 1 07 00 08 80000001
1 08 0 1 08 09 09 00000000
1 09 0 1 09 00 0a fffff00f
1 0a 0 1 0a 0b 0b 00000000
1 0b 0 1 0b 00 0c 00000007
1 0c 0 1 0c 0d 0d 00000000
1 0d 0 1 0d 00 0e 0000001f
1 0e 0 1 0e 0f 0f 00000000
1 0f 0 1 0f 00 10 00000004
1 10 0 1 10 11 11 00000000
1 11 0 1 12 00 12 fffffff0
1 12 0 1 13 14 13 00000000
1 13 0 1 14 00 14 00000fff
1 02 0 1 15 16 16 00000000
1 01 0 1 00 00 00 0000abcd
1 01 0 1 00 00 17 00000000
1 01 0 1 00 00 19 00000011
1 01 0 1 00 00 19 00000022
1 00 0 1 19 19 1a 00000000
1 01 2 0 00 1a 00 00000008
1 01 1 3 00 00 1b 00000008
0 00 0 0 00 00 00 00000000
1 01 0 1 1b 00 1c 00000001
1 01 1 3 05 00 1d 00000000
1 20 0 0 1a 1a 00 00000000
1 40 0 0 03 04 00 00000000
1 60 0 0 03 04 00 00000000
1 80 0 0 1a 1c 00 00000000
1 a0 0 0 04 05 00 00000000
1 c0 0 0 1c 1a 00 00000000

// File: files.f
design/ex_pkg.sv
design/forward_unit.sv
design/alu.sv
design/branch_unit.sv
design/execute_stage.sv
design/retire_latches.sv
design/ex_pipeline.sv
testbench/ex_pipeline_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = ex_pipeline_tb
FILELIST  = files.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
